//--- sig_align_cases.txt
# name status_async(hex) sample_valid sample_data(hex) check_kind expected_kind
# kind codes: 0 none, 1 rise, 2 fall, 3 mixed; one line per clock cycle
rst_win0 a5 1 1111 1 0
rst_win1 3c 1 2222 1 0
rst_win2 ff 1 3333 1 0
rst_win3 ff 1 4444 1 0
first_rise 01 0 0000 1 1
align_steady0 01 1 abcd 1 0
align_steady1 01 1 1234 1 0
rise_only 0f 1 0007 1 1
fall_only 03 1 0008 1 2
mixed 30 1 0009 1 3
steady_idle 30 0 0000 1 0
status_only_rise 70 0 dead 1 1
status_only_fall 40 0 beef 1 2
status_only_mixed 81 0 0000 1 3
stream0 82 1 0100 1 3
stream1 83 1 0101 1 1
stream2 03 1 0102 1 2
stream3 f3 1 0103 1 1
stream4 0c 1 0104 1 3
stream5 00 1 0105 1 2
stream6 ff 1 0106 1 1
stream7 00 1 0107 1 2
stream8 55 1 0108 1 1
stream9 aa 1 0109 1 3
hold_end aa 1 ffff 1 0

//--- filelist.f
sig_align_pkg.sv
reset_sync.sv
full_synchronizer.sv
pipeline_stall.sv
edge_tagger.sv
sig_align_top.sv
tb_clock_gen.sv
sig_align_tb.sv

//--- sig_align_tb.sv
// ##########################################################
// Testbench for the status-alignment front end
// File-driven cases, LCG traffic, reference model, checks
// ##########################################################

`timescale 1ns/1ps

module sig_align_tb import sig_align_pkg::*; ();

  localparam int    CLK_PERIOD_NS = 100;
  localparam int    RESET_CYCLES  = 4;
  localparam int    RANDOM_LINES  = 24;
  // Two synchronizer ranks plus the record register
  localparam int    LATENCY       = SYNC_STAGES + 1;
  localparam string CASES_FILE    = "sig_align_cases.txt";

  logic                clk;
  logic                rst_n;
  logic [STATUS_W-1:0] status_async;
  sample_t             sample_in;
  aligned_t            rec_out;

  // One entry per applied cycle
  string               name_q[$];
  logic [STATUS_W-1:0] status_q[$];
  sample_t             sample_q[$];
  bit                  exp_en_q[$];
  event_kind_e         exp_kind_q[$];

  int          n_file_lines;
  bit          cases_loaded;
  bit          test_fail;
  int          test_count;
  int          pass_count;
  int          fail_count;
  int          error_count;
  logic [31:0] lcg_state;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen_i (.clk(clk));

  sig_align_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .status_async (status_async),
    .sample_in    (sample_in),
    .rec_out      (rec_out)
  );

  // Numerical Recipes LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected record for the cycle whose input was applied at index src
  function automatic aligned_t model_record(input int src);
    aligned_t            r;
    logic [STATUS_W-1:0] prev;
    logic [STATUS_W-1:0] rise;
    logic [STATUS_W-1:0] fall;
    r = '0;
    // Core leaves reset RESET_HOLD cycles after rst_n rises at index 0
    if (src >= RESET_HOLD) begin
      prev      = (src - 1 >= RESET_HOLD) ? status_q[src-1] : '0;
      r.status  = status_q[src];
      r.changed = r.status ^ prev;
      rise      = r.changed & r.status;
      fall      = r.changed & prev;
      if (rise != '0 && fall != '0) r.kind = EV_MIXED;
      else if (rise != '0)          r.kind = EV_RISE;
      else if (fall != '0)          r.kind = EV_FALL;
      else                          r.kind = EV_NONE;
      r.sample  = sample_q[src];
      r.valid   = r.sample.valid || (r.changed != '0);
    end
    return r;
  endfunction

  task automatic check_record(input string name, input aligned_t exp, input aligned_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected record %h actual record %h", name, exp, act);
      test_fail = 1'b1;
      error_count++;
    end
  endtask

  task automatic check_kind(input string name, input event_kind_e exp, input event_kind_e act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected kind %s actual kind %s", name, exp.name(), act.name());
      test_fail = 1'b1;
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (test_fail) begin
      fail_count++;
      $display("FAIL  %s", name);
    end else begin
      pass_count++;
      $display("PASS  %s", name);
    end
  endtask

  task automatic push_entry(input string name, input logic [STATUS_W-1:0] st,
                            input sample_t smp, input bit en, input event_kind_e kind);
    name_q.push_back(name);
    status_q.push_back(st);
    sample_q.push_back(smp);
    exp_en_q.push_back(en);
    exp_kind_q.push_back(kind);
  endtask

  // Columns: name, status (hex), valid, data (hex), check flag, kind code
  task automatic load_cases(output bit ok);
    int                  fd;
    int                  n;
    int                  v;
    int                  en;
    int                  k;
    string               line;
    string               name;
    logic [STATUS_W-1:0] st;
    logic [DATA_W-1:0]   d;
    sample_t             smp;
    ok = 1'b0;
    fd = $fopen(CASES_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %h %d %h %d %d", name, st, v, d, en, k);
        // Comment and blank lines never give six fields
        if (n == 6 && name.substr(0, 0) != "#") begin
          smp.valid = (v != 0);
          smp.data  = d;
          push_entry(name, st, smp, en != 0, event_kind_e'(k[1:0]));
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  task automatic add_random_lines(input int count);
    sample_t smp;
    for (int i = 0; i < count; i++) begin
      lcg_state = lcg_next(lcg_state);
      smp.valid = lcg_state[28];
      lcg_state = lcg_next(lcg_state);
      smp.data  = lcg_state[31:16];
      lcg_state = lcg_next(lcg_state);
      push_entry($sformatf("rand_%0d", i), lcg_state[31:24], smp, 1'b0, EV_NONE);
    end
  endtask

  // Idle cycles that flush the last records out of the pipeline
  task automatic add_drain_lines(input int count);
    logic [STATUS_W-1:0] last;
    last = (status_q.size() > 0) ? status_q[$] : '0;
    for (int i = 0; i < count; i++) begin
      push_entry("drain", last, '0, 1'b0, EV_NONE);
    end
  endtask

  initial begin
    bit ok;
    int total;
    int src;
    rst_n        = 1'b0;
    status_async = '0;
    sample_in    = '0;
    cases_loaded = 1'b0;
    test_count   = 0;
    pass_count   = 0;
    fail_count   = 0;
    error_count  = 0;
    lcg_state    = 32'h74fb_8c79;
    load_cases(ok);
    if (!ok) begin
      $display("ERROR: could not open the case file %s", CASES_FILE);
      error_count++;
    end
    n_file_lines = name_q.size();
    add_random_lines(RANDOM_LINES);
    add_drain_lines(LATENCY);
    cases_loaded = 1'b1;
    total        = name_q.size();
    // rst_n low phase, record must be cleared once the core reset has reached the tagger
    test_fail = 1'b0;
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(negedge clk);
      if (i > 0) check_record("reset_hold", '0, rec_out);
    end
    for (int j = 0; j < total; j++) begin
      @(negedge clk);
      // Sample first, then drive the next cycle
      if (j < LATENCY) begin
        check_record("reset_hold", '0, rec_out);
        if (j == LATENCY - 1) finish_test("reset_hold");
      end else begin
        src = j - LATENCY;
        test_fail = 1'b0;
        check_record(name_q[src], model_record(src), rec_out);
        if (exp_en_q[src]) check_kind(name_q[src], exp_kind_q[src], rec_out.kind);
        finish_test(name_q[src]);
      end
      if (j == 0) rst_n = 1'b1;
      status_async = status_q[j];
      sample_in    = sample_q[j];
    end
    $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
             test_count, pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the number of cycles the run needs
  initial begin
    wait (cases_loaded);
    #((n_file_lines + RANDOM_LINES + 20) * CLK_PERIOD_NS);
    $display("ERROR: timeout, the run did not finish within %0d clock periods",
             n_file_lines + RANDOM_LINES + 20);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
// ##########################################################
// Free-running testbench clock source
// ##########################################################

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // Starts low so the first rising edge lands at half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- sig_align_top.sv
// ##########################################################
// Status-alignment front end top level
// ##########################################################

`timescale 1ns/1ps

module sig_align_top import sig_align_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [STATUS_W-1:0] status_async,
  input  sample_t             sample_in,
  output aligned_t            rec_out
);

  // Conditioned reset shared by every stage
  logic core_rst;

  // Synchronized status
  logic [STATUS_W-1:0] status_sync;

  // Sample as a flat vector around the delay line
  logic [$bits(sample_t)-1:0] sample_flat_in;
  logic [$bits(sample_t)-1:0] sample_flat_dly;
  sample_t                    sample_dly;

  assign sample_flat_in = sample_in;
  assign sample_dly     = sample_t'(sample_flat_dly);

  reset_sync reset_sync_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .core_rst (core_rst)
  );

  full_synchronizer full_synchronizer_i (
    .clk          (clk),
    .core_rst     (core_rst),
    .status_async (status_async),
    .status_sync  (status_sync)
  );

  // Sample delay matches the synchronizer depth
  pipeline_stall #(
    .WIDTH ($bits(sample_t)),
    .DELAY (SYNC_STAGES)
  ) pipeline_stall_i (
    .clk      (clk),
    .core_rst (core_rst),
    .datain   (sample_flat_in),
    .dataout  (sample_flat_dly)
  );

  edge_tagger edge_tagger_i (
    .clk         (clk),
    .core_rst    (core_rst),
    .status_sync (status_sync),
    .sample_dly  (sample_dly),
    .rec_out     (rec_out)
  );

endmodule

//--- edge_tagger.sv
// ##########################################################
// Edge tagger that detects and classifies status changes
// and registers the aligned record
// ##########################################################

`timescale 1ns/1ps

module edge_tagger import sig_align_pkg::*; (
  input  logic                clk,
  input  logic                core_rst,
  input  logic [STATUS_W-1:0] status_sync,
  input  sample_t             sample_dly,
  output aligned_t            rec_out
);

  // Status seen one cycle earlier
  logic [STATUS_W-1:0] prev_status_q;

  // Change decode
  logic [STATUS_W-1:0] changed;
  logic [STATUS_W-1:0] rise_set;
  logic [STATUS_W-1:0] fall_set;
  event_kind_e         kind;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      // All-zero history makes the first set bit a rise
      prev_status_q <= '0;
    end else begin
      prev_status_q <= status_sync;
    end
  end

  // Any toggled bit
  assign changed  = status_sync ^ prev_status_q;
  // Toggled and now high
  assign rise_set = changed & status_sync;
  // Toggled and previously high
  assign fall_set = changed & prev_status_q;

  always_comb begin
    unique case ({|fall_set, |rise_set})
      2'b00:   kind = EV_NONE;
      2'b01:   kind = EV_RISE;
      2'b10:   kind = EV_FALL;
      default: kind = EV_MIXED;
    endcase
  end

  // Record register
  always_ff @(posedge clk) begin
    if (core_rst) begin
      rec_out <= '0;
    end else begin
      // Record matters for a real sample or for any status event
      rec_out.valid   <= sample_dly.valid || (|changed);
      rec_out.kind    <= kind;
      rec_out.changed <= changed;
      rec_out.status  <= status_sync;
      // Sample travels along even when invalid
      rec_out.sample  <= sample_dly;
    end
  end

  // Kind and mask agree in every registered record
  assert property (@(posedge clk)
    !core_rst |=> (rec_out.kind == EV_NONE) == (rec_out.changed == '0));

  // Nothing valid leaves while the core is in reset
  assert property (@(posedge clk) core_rst |=> !rec_out.valid);

endmodule

//--- pipeline_stall.sv
// ##########################################################
// Parameterized shift-register delay line
// ##########################################################

`timescale 1ns/1ps

module pipeline_stall #(
  parameter int WIDTH = 1,
  parameter int DELAY = 2
) (
  input  logic             clk,
  input  logic             core_rst,
  input  logic [WIDTH-1:0] datain,
  output logic [WIDTH-1:0] dataout
);

  // WIDTH x DELAY storage
  // Slice 0 is the newest entry, slice DELAY-1 the oldest
  logic [DELAY-1:0][WIDTH-1:0] dly_q;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      dly_q <= '0;
    end else begin
      dly_q[0] <= datain;
      // Every other slice takes its younger neighbour
      for (int i = 1; i < DELAY; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  // Oldest slice leaves the line
  assign dataout = dly_q[DELAY-1];

  // Entry slice loads the input
  assert property (@(posedge clk) !core_rst |=> dly_q[0] == $past(datain));

  // Each further slice advances by one position per reset-free edge
  for (genvar g = 1; g < DELAY; g++) begin : g_shift_chk
    assert property (@(posedge clk) !core_rst |=> dly_q[g] == $past(dly_q[g-1]));
  end

  // End-to-end latency is DELAY once the line has been filled
  assert property (@(posedge clk)
    !core_rst [*DELAY] |=> dataout == $past(datain, DELAY));

endmodule

//--- full_synchronizer.sv
// ##########################################################
// Two-stage synchronizer for the asynchronous status lines
// ##########################################################

`timescale 1ns/1ps

module full_synchronizer import sig_align_pkg::*; (
  input  logic                clk,
  input  logic                core_rst,
  input  logic [STATUS_W-1:0] status_async,
  output logic [STATUS_W-1:0] status_sync
);

  // First rank catches the raw lines
  logic [STATUS_W-1:0] meta_q;
  // Second rank gives a settled value
  logic [STATUS_W-1:0] sync_q;

  always_ff @(posedge clk) begin
    if (core_rst) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= status_async;
      sync_q <= meta_q;
    end
  end

  assign status_sync = sync_q;

  // Two reset-free edges give a two-cycle-old copy of the input
  assert property (@(posedge clk)
    !core_rst [*2] |=> status_sync == $past(status_async, 2));

  // Known input history leads to a known output
  assert property (@(posedge clk)
    (!core_rst && !$isunknown(status_async)) ##1 !core_rst |=> !$isunknown(status_sync));

endmodule

//--- reset_sync.sv
// ##########################################################
// Reset conditioner that stretches rst_n into core_rst
// ##########################################################

`timescale 1ns/1ps

module reset_sync import sig_align_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  output logic core_rst
);

  // Hold register
  // All ones while rst_n is low, then drains towards the top bit
  logic [RESET_HOLD-1:0] hold_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hold_q <= '1;
    end else begin
      hold_q <= {hold_q[RESET_HOLD-2:0], 1'b0};
    end
  end

  // Top bit is the last one to clear
  assign core_rst = hold_q[RESET_HOLD-1];

  // Low rst_n at an edge forces core reset right after it
  assert property (@(posedge clk) !rst_n |=> core_rst);

  // No glitch back into reset while rst_n stays high
  assert property (@(posedge clk) (!core_rst && rst_n) |=> !core_rst);

  // Release after exactly RESET_HOLD high samples
  assert property (@(posedge clk) rst_n [*RESET_HOLD] |=> !core_rst);

endmodule

//--- sig_align_pkg.sv
// ##########################################################
// Shared widths, depths and record types for the
// status-alignment front end
// ##########################################################

package sig_align_pkg;

  // Asynchronous status bus width
  localparam int STATUS_W = 8;

  // Sample payload width
  localparam int DATA_W = 16;

  // Synchronizer depth
  // Also used as the sample delay so both paths line up
  localparam int SYNC_STAGES = 2;

  // Cycles the core reset is held after rst_n rises
  localparam int RESET_HOLD = 4;

  // Synchronous data sample
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } sample_t;

  // Change classification of one status step
  typedef enum logic [1:0] {
    EV_NONE  = 2'b00,  // no bit changed
    EV_RISE  = 2'b01,  // only 0 to 1 changes
    EV_FALL  = 2'b10,  // only 1 to 0 changes
    EV_MIXED = 2'b11   // both directions in the same cycle
  } event_kind_e;

  // One aligned output record per cycle
  typedef struct packed {
    logic                valid;
    event_kind_e         kind;
    logic [STATUS_W-1:0] changed;
    logic [STATUS_W-1:0] status;
    sample_t             sample;
  } aligned_t;

endpackage
